// File: dv/sb_model.svh
// Scoreboard reference model
`ifndef SB_MODEL_SVH
`define SB_MODEL_SVH

// ------------------------------------------------------------
// model state, mirrors slots, pointers and count
// ------------------------------------------------------------
sb_entry_t [SB_ENTRIES-1:0] m_slot;
logic [SB_ENTRIES-1:0]      m_issued;
trans_id_t                  m_iptr;
trans_id_t                  m_cptr;
int unsigned                m_cnt;

task automatic model_reset();
  m_slot   = '0;
  m_issued = '0;
  m_iptr   = '0;
  m_cptr   = '0;
  m_cnt    = 0;
endtask

// one slot stays free, so seven in flight means full
function automatic logic model_full();
  return m_cnt == SB_ENTRIES - 1;
endfunction

// oldest issued slot by index decides, x0 never clobbered
function automatic fu_t model_clobber(int unsigned r);
  if (r == 0) return FU_NONE;
  for (int unsigned s = 0; s < SB_ENTRIES; s++) begin
    if (m_issued[s] && m_slot[s].rd == REG_ADDR_SIZE'(r)) return m_slot[s].fu;
  end
  return FU_NONE;
endfunction

// returns {valid, data}
function automatic logic [XLEN:0] model_fwd(logic [REG_ADDR_SIZE-1:0] rs);
  if (rs == '0) return '0;
  // results on the write-back ports beat stored results
  for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
    if (wb[k].valid && !wb[k].ex.valid && m_slot[wb[k].trans_id].rd == rs) begin
      return {1'b1, wb[k].data};
    end
  end
  for (int unsigned s = 0; s < SB_ENTRIES; s++) begin
    if (m_issued[s] && m_slot[s].valid && m_slot[s].rd == rs) begin
      return {1'b1, m_slot[s].result};
    end
  end
  return '0;
endfunction

// commit port i looks at head + i
function automatic sb_entry_t model_commit(int unsigned i);
  sb_entry_t e;
  trans_id_t id;
  id         = m_cptr + trans_id_t'(i);
  e          = m_slot[id];
  e.trans_id = id;
  return e;
endfunction

// advance the model by one clock edge using the current inputs
task automatic model_step();
  sb_entry_t [SB_ENTRIES-1:0] nxt;
  logic [SB_ENTRIES-1:0]      niss;
  logic                       accept;
  trans_id_t                  id;
  int unsigned                n_commit;
  nxt      = m_slot;
  niss     = m_issued;
  n_commit = 0;
  accept   = dec_valid && issue_ack && !model_full() && !flush_unissued;
  if (accept) begin
    nxt[m_iptr]          = decoded;
    nxt[m_iptr].trans_id = m_iptr;
    nxt[m_iptr].valid    = 1'b0;
    niss[m_iptr]         = 1'b1;
  end
  // entries without a unit finish by themselves
  for (int unsigned s = 0; s < SB_ENTRIES; s++) begin
    if (m_issued[s] && m_slot[s].fu == FU_NONE) nxt[s].valid = 1'b1;
  end
  for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
    if (wb[k].valid && m_issued[wb[k].trans_id]) begin
      nxt[wb[k].trans_id].valid  = 1'b1;
      nxt[wb[k].trans_id].result = wb[k].data;
      if (wb[k].ex.valid) nxt[wb[k].trans_id].ex = wb[k].ex;
    end
  end
  for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
    if (commit_ack[i]) begin
      id            = m_cptr + trans_id_t'(i);
      niss[id]      = 1'b0;
      nxt[id].valid = 1'b0;
      n_commit++;
    end
  end
  if (flush) begin
    niss = '0;
    for (int unsigned s = 0; s < SB_ENTRIES; s++) nxt[s].valid = 1'b0;
    m_iptr = '0;
    m_cptr = '0;
    m_cnt  = 0;
  end else begin
    m_iptr = m_iptr + trans_id_t'(accept);
    m_cptr = m_cptr + trans_id_t'(n_commit);
    m_cnt  = m_cnt - n_commit + (accept ? 1 : 0);
  end
  m_slot   = nxt;
  m_issued = niss;
endtask

`endif

// File: dv/tb_scoreboard.sv
// Scoreboard testbench
`timescale 1ns/1ps

module tb_scoreboard import sb_pkg::*; ();

  localparam int unsigned NR_WB_PORTS     = 1;
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned CLK_PERIOD      = 100;
  localparam int unsigned STIM_DELAY      = 10;
  localparam int unsigned N_CYCLES        = 3000;

  logic                            clk;
  logic                            rst_n;
  logic                            flush;
  logic                            flush_unissued;
  logic                            unres;
  logic                            sb_full;
  sb_entry_t                       decoded;
  logic                            dec_valid;
  logic                            dec_ack;
  sb_entry_t                       issue_instr;
  logic                            issue_valid;
  logic                            issue_ack;
  wb_port_t [NR_WB_PORTS-1:0]      wb;
  sb_entry_t [NR_COMMIT_PORTS-1:0] commit_instr;
  logic [NR_COMMIT_PORTS-1:0]      commit_ack;
  fu_t [NR_REGS-1:0]               clobber;
  logic [REG_ADDR_SIZE-1:0]        rs1;
  logic [REG_ADDR_SIZE-1:0]        rs2;
  logic [XLEN-1:0]                 rs1_data;
  logic [XLEN-1:0]                 rs2_data;
  logic                            rs1_valid;
  logic                            rs2_valid;
  int                              seed;

  `include "sb_model.svh"

  scoreboard #(
    .NR_WB_PORTS     (NR_WB_PORTS),
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) i_scoreboard (
    .clk_i                  (clk),
    .rst_ni                 (rst_n),
    .sb_full_o              (sb_full),
    .flush_unissued_instr_i (flush_unissued),
    .flush_i                (flush),
    .unresolved_branch_i    (unres),
    .rd_clobber_o           (clobber),
    .rs1_i                  (rs1),
    .rs1_o                  (rs1_data),
    .rs1_valid_o            (rs1_valid),
    .rs2_i                  (rs2),
    .rs2_o                  (rs2_data),
    .rs2_valid_o            (rs2_valid),
    .commit_instr_o         (commit_instr),
    .commit_ack_i           (commit_ack),
    .decoded_instr_i        (decoded),
    .decoded_instr_valid_i  (dec_valid),
    .decoded_instr_ack_o    (dec_ack),
    .issue_instr_o          (issue_instr),
    .issue_instr_valid_o    (issue_valid),
    .issue_ack_i            (issue_ack),
    .wb_i                   (wb)
  );

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_entry(string name, sb_entry_t got, sb_entry_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_fu(string name, fu_t got, fu_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %s, expected %s", $time, name, got.name(), exp.name());
      stop_on_error();
    end
  endtask

  // data only matters when a result is forwarded
  task automatic check_data(string name, logic [XLEN-1:0] got, logic got_v,
                            logic [XLEN-1:0] exp, logic exp_v);
    if (got_v !== exp_v || (exp_v && got !== exp)) begin
      $display("Fail at %0t ns: %s is %b/%h, expected %b/%h", $time, name,
               got_v, got, exp_v, exp);
      stop_on_error();
    end
  endtask

  // ------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------
  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic init_inputs();
    flush          = 1'b0;
    flush_unissued = 1'b0;
    unres          = 1'b0;
    decoded        = '0;
    dec_valid      = 1'b0;
    issue_ack      = 1'b0;
    wb             = '0;
    commit_ack     = '0;
    rs1            = '0;
    rs2            = '0;
  endtask

  // every third block of 100 cycles runs without commits or flush to fill up
  task automatic drive_inputs(int unsigned cyc);
    logic      fill;
    logic      ack_ok;
    trans_id_t id;
    fill             = ((cyc / 100) % 3) == 1;
    dec_valid        = rand_below(4) != 0;
    decoded.pc       = $random(seed);
    decoded.trans_id = trans_id_t'(rand_below(SB_ENTRIES));
    decoded.fu       = fu_t'(3'(rand_below(6)));
    // few destinations so slots collide often
    decoded.rd       = REG_ADDR_SIZE'(rand_below(8));
    decoded.result   = $random(seed);
    decoded.valid    = rand_below(2) == 0;
    decoded.ex.valid = rand_below(8) == 0;
    decoded.ex.cause = 6'(rand_below(64));
    unres            = rand_below(8) == 0;
    issue_ack        = dec_valid && !unres && !model_full() && rand_below(4) != 0;
    flush_unissued   = rand_below(10) == 0;
    flush            = !fill && rand_below(60) == 0;
    for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
      wb[k].valid    = rand_below(2) == 0;
      wb[k].trans_id = trans_id_t'(rand_below(SB_ENTRIES));
      wb[k].data     = $random(seed);
      wb[k].ex.valid = rand_below(6) == 0;
      wb[k].ex.cause = 6'(rand_below(64));
    end
    // acks stay contiguous and only reach finished entries
    ack_ok = !fill;
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      id            = m_cptr + trans_id_t'(i);
      ack_ok        = ack_ok && m_issued[id] && m_slot[id].valid && rand_below(3) != 0;
      commit_ack[i] = ack_ok;
    end
    rs1 = REG_ADDR_SIZE'(rand_below(8));
    rs2 = REG_ADDR_SIZE'(rand_below(8));
  endtask

  task automatic check_outputs();
    logic          exp_full;
    sb_entry_t     exp_issue;
    logic [XLEN:0] fwd;
    trans_id_t     id;
    exp_full = model_full();
    check_bit("sb_full_o", sb_full, exp_full);
    check_bit("issue_instr_valid_o", issue_valid, dec_valid & ~unres & ~exp_full);
    check_bit("decoded_instr_ack_o", dec_ack, issue_ack & ~exp_full);
    exp_issue          = decoded;
    exp_issue.trans_id = m_iptr;
    check_entry("issue_instr_o", issue_instr, exp_issue);
    // free slots only have to show valid low
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      id = m_cptr + trans_id_t'(i);
      if (m_issued[id]) begin
        check_entry($sformatf("commit_instr_o[%0d]", i), commit_instr[i], model_commit(i));
      end else begin
        check_bit($sformatf("commit_instr_o[%0d].valid", i), commit_instr[i].valid, 1'b0);
      end
    end
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      check_fu($sformatf("rd_clobber_o[%0d]", r), clobber[r], model_clobber(r));
    end
    fwd = model_fwd(rs1);
    check_data("rs1_o", rs1_data, rs1_valid, fwd[XLEN-1:0], fwd[XLEN]);
    fwd = model_fwd(rs2);
    check_data("rs2_o", rs2_data, rs2_valid, fwd[XLEN-1:0], fwd[XLEN]);
  endtask

  // ------------------------------------------------------------
  // clock, stimulus and watchdog
  // ------------------------------------------------------------
  initial begin : p_clk
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : p_stim
    seed  = 32'ha8ad_bbac;
    rst_n = 1'b0;
    init_inputs();
    model_reset();
    repeat (3) @(posedge clk);
    #STIM_DELAY;
    // outputs while still in reset
    check_outputs();
    rst_n = 1'b1;
    for (int unsigned cyc = 0; cyc < N_CYCLES; cyc++) begin
      drive_inputs(cyc);
      // sample mid cycle, then step the model to the next edge
      #(CLK_PERIOD / 2 - STIM_DELAY);
      check_outputs();
      model_step();
      @(posedge clk);
      #STIM_DELAY;
    end
    $display("NO ERRORS");
    $finish;
  end

  initial begin : p_watchdog
    #(2 * N_CYCLES * CLK_PERIOD);
    $display("timeout: the test did not finish within %0d clock cycles", 2 * N_CYCLES);
    stop_on_error();
  end

endmodule

// File: hdl/sb_clobber.sv
// Destination clobber map
`timescale 1ns/1ps

module sb_clobber import sb_pkg::*; (
  input  logic [SB_ENTRIES-1:0]      slot_issued_i,
  input  sb_entry_t [SB_ENTRIES-1:0] slot_entry_i,
  // unit that will write each register or FU_NONE when free
  output fu_t [NR_REGS-1:0]          rd_clobber_o
);

  // ----------------------------------------------------------
  // per-register select
  // ----------------------------------------------------------
  // walk high to low so the lowest issued slot index lands last
  always_comb begin : p_clobber
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      rd_clobber_o[r] = FU_NONE;
      for (int s = SB_ENTRIES - 1; s >= 0; s--) begin
        if (slot_issued_i[s] && slot_entry_i[s].rd == REG_ADDR_SIZE'(r)) begin
          rd_clobber_o[r] = slot_entry_i[s].fu;
        end
      end
    end
    // x0 is never written
    rd_clobber_o[0] = FU_NONE;
  end

endmodule

// File: hdl/sb_entry_store.sv
// Scoreboard slot store
`timescale 1ns/1ps

module sb_entry_store import sb_pkg::*; #(
  parameter int unsigned NR_WB_PORTS     = 1,
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  logic                                  flush_unissued_instr_i,
  // decode side
  input  sb_entry_t                             decoded_instr_i,
  input  logic                                  decoded_instr_valid_i,
  output logic                                  decoded_instr_ack_o,
  // issue side
  output sb_entry_t                             issue_instr_o,
  output logic                                  issue_instr_valid_o,
  input  logic                                  issue_ack_i,
  input  logic                                  unresolved_branch_i,
  output logic                                  sb_full_o,
  // write-back ports
  input  wb_port_t [NR_WB_PORTS-1:0]            wb_i,
  // commit side, oldest entry on port 0
  output sb_entry_t [NR_COMMIT_PORTS-1:0]       commit_instr_o,
  input  logic [NR_COMMIT_PORTS-1:0]            commit_ack_i,
  // raw slot view for clobber map and forwarding
  output logic [SB_ENTRIES-1:0]                 slot_issued_o,
  output sb_entry_t [SB_ENTRIES-1:0]            slot_entry_o
);

  localparam int unsigned NCOMMIT_BITS = $clog2(NR_COMMIT_PORTS) + 1;

  sb_entry_t [SB_ENTRIES-1:0] slot_q, slot_n;
  logic [SB_ENTRIES-1:0]      issued_q, issued_n;
  trans_id_t                  issue_ptr_q, issue_ptr_n;
  trans_id_t                  commit_ptr_q, commit_ptr_n;
  logic [TRANS_ID_BITS-1:0]   cnt_q, cnt_n;
  logic                       full;
  logic                       issue_en;
  logic [NCOMMIT_BITS-1:0]    num_commit;

  // full at SB_ENTRIES-1 so the counter never wraps
  assign full      = &cnt_q;
  assign sb_full_o = full;

  // ----------------------------------------------------------
  // issue and decode handshake
  // ----------------------------------------------------------
  always_comb begin : p_issue
    issue_instr_o          = decoded_instr_i;
    // slot index doubles as the transaction id
    issue_instr_o.trans_id = issue_ptr_q;
    issue_instr_valid_o    = decoded_instr_valid_i & ~unresolved_branch_i & ~full;
    decoded_instr_ack_o    = issue_ack_i & ~full;
  end

  assign issue_en = decoded_instr_valid_i & decoded_instr_ack_o & ~flush_unissued_instr_i;

  // commit ports show consecutive slots starting at the head
  always_comb begin : p_commit_ports
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      commit_instr_o[i]          = slot_q[commit_ptr_q + trans_id_t'(i)];
      commit_instr_o[i].trans_id = commit_ptr_q + trans_id_t'(i);
    end
  end

  // acks are contiguous from port 0, a plain count is enough
  always_comb begin : p_num_commit
    num_commit = '0;
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      num_commit = num_commit + NCOMMIT_BITS'(commit_ack_i[i]);
    end
  end

  // ----------------------------------------------------------
  // slot next state
  // ----------------------------------------------------------
  always_comb begin : p_slot_update
    slot_n   = slot_q;
    issued_n = issued_q;

    // new entry at the issue pointer, result not ready yet
    if (issue_en) begin
      slot_n[issue_ptr_q]       = issue_instr_o;
      slot_n[issue_ptr_q].valid = 1'b0;
      issued_n[issue_ptr_q]     = 1'b1;
    end

    // no unit behind it, done one cycle after issue
    for (int unsigned i = 0; i < SB_ENTRIES; i++) begin
      if (issued_q[i] && slot_q[i].fu == FU_NONE) begin
        slot_n[i].valid = 1'b1;
      end
    end

    // write-back, stale results for freed slots are dropped
    for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
      if (wb_i[k].valid && issued_q[wb_i[k].trans_id]) begin
        slot_n[wb_i[k].trans_id].valid  = 1'b1;
        slot_n[wb_i[k].trans_id].result = wb_i[k].data;
        // keep the decode exception unless the unit raised one
        if (wb_i[k].ex.valid) begin
          slot_n[wb_i[k].trans_id].ex = wb_i[k].ex;
        end
      end
    end

    // retired slots become free
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      if (commit_ack_i[i]) begin
        issued_n[commit_ptr_q + trans_id_t'(i)]     = 1'b0;
        slot_n[commit_ptr_q + trans_id_t'(i)].valid = 1'b0;
      end
    end

    // flush drops everything in flight
    if (flush_i) begin
      issued_n = '0;
      for (int unsigned i = 0; i < SB_ENTRIES; i++) begin
        slot_n[i].valid    = 1'b0;
        slot_n[i].ex.valid = 1'b0;
      end
    end
  end

  // pointer and count updates
  assign issue_ptr_n  = issue_ptr_q + trans_id_t'(issue_en);
  assign commit_ptr_n = commit_ptr_q + trans_id_t'(num_commit);
  assign cnt_n        = cnt_q - TRANS_ID_BITS'(num_commit) + TRANS_ID_BITS'(issue_en);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      slot_q       <= '0;
      issued_q     <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      slot_q   <= slot_n;
      issued_q <= issued_n;
      if (flush_i) begin
        issue_ptr_q  <= '0;
        commit_ptr_q <= '0;
        cnt_q        <= '0;
      end else begin
        issue_ptr_q  <= issue_ptr_n;
        commit_ptr_q <= commit_ptr_n;
        cnt_q        <= cnt_n;
      end
    end
  end

  assign slot_issued_o = issued_q;
  assign slot_entry_o  = slot_q;

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // commit stage only retires finished entries
  for (genvar i = 0; i < NR_COMMIT_PORTS; i++) begin : gen_ack_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_ack_i[i] |-> commit_instr_o[i].valid)
      else $error("commit ack on port %0d without a finished entry", i);
  end

  // issue stage only acks what it was offered
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_instr_valid_o)
    else $error("issue ack while no instruction is offered");

  // no two units finish the same transaction in one cycle
  for (genvar i = 0; i < NR_WB_PORTS; i++) begin : gen_wb_chk_i
    for (genvar j = i + 1; j < NR_WB_PORTS; j++) begin : gen_wb_chk_j
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_i[i].valid && wb_i[j].valid) |-> (wb_i[i].trans_id != wb_i[j].trans_id))
        else $error("write-back ports %0d and %0d share a transaction id", i, j);
    end
  end

endmodule

// File: hdl/sb_operand_fwd.sv
// Operand forwarding
`timescale 1ns/1ps

module sb_operand_fwd import sb_pkg::*; #(
  parameter int unsigned NR_WB_PORTS = 1
) (
  input  logic [SB_ENTRIES-1:0]      slot_issued_i,
  input  sb_entry_t [SB_ENTRIES-1:0] slot_entry_i,
  input  wb_port_t [NR_WB_PORTS-1:0] wb_i,
  // source register reads
  input  logic [REG_ADDR_SIZE-1:0]   rs1_i,
  output logic [XLEN-1:0]            rs1_o,
  output logic                       rs1_valid_o,
  input  logic [REG_ADDR_SIZE-1:0]   rs2_i,
  output logic [XLEN-1:0]            rs2_o,
  output logic                       rs2_valid_o
);

  // write-back ports first, then slots
  localparam int unsigned NR_CAND = NR_WB_PORTS + SB_ENTRIES;

  typedef struct packed {
    logic            hit;
    logic [XLEN-1:0] data;
  } fwd_t;

  logic [NR_CAND-1:0]                    cand_ok;
  logic [NR_CAND-1:0][REG_ADDR_SIZE-1:0] cand_rd;
  logic [NR_CAND-1:0][XLEN-1:0]          cand_data;
  fwd_t                                  rs1_fwd;
  fwd_t                                  rs2_fwd;

  // fixed priority, index 0 highest
  function automatic fwd_t fwd_pick(
    input logic [REG_ADDR_SIZE-1:0]        rs,
    input logic [NR_CAND-1:0]              ok,
    input logic [NR_CAND-1:0][REG_ADDR_SIZE-1:0] rd,
    input logic [NR_CAND-1:0][XLEN-1:0]    data
  );
    fwd_t res;
    res = '0;
    // walk up from lowest priority so the first match overwrites
    for (int i = int'(NR_CAND) - 1; i >= 0; i--) begin
      if (ok[i] && rd[i] == rs) begin
        res.hit  = 1'b1;
        res.data = data[i];
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // candidate list
  // ----------------------------------------------------------
  always_comb begin : p_cand
    // results arriving this cycle, rd comes from the target slot
    for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
      cand_ok[k]   = wb_i[k].valid & ~wb_i[k].ex.valid;
      cand_rd[k]   = slot_entry_i[wb_i[k].trans_id].rd;
      cand_data[k] = wb_i[k].data;
    end
    // finished results still waiting for commit
    for (int unsigned s = 0; s < SB_ENTRIES; s++) begin
      cand_ok[NR_WB_PORTS+s]   = slot_issued_i[s] & slot_entry_i[s].valid;
      cand_rd[NR_WB_PORTS+s]   = slot_entry_i[s].rd;
      cand_data[NR_WB_PORTS+s] = slot_entry_i[s].result;
    end
  end

  // ----------------------------------------------------------
  // source selects
  // ----------------------------------------------------------
  assign rs1_fwd = fwd_pick(rs1_i, cand_ok, cand_rd, cand_data);
  assign rs2_fwd = fwd_pick(rs2_i, cand_ok, cand_rd, cand_data);

  assign rs1_o = rs1_fwd.data;
  assign rs2_o = rs2_fwd.data;

  // x0 reads come from the register file
  assign rs1_valid_o = rs1_fwd.hit & (rs1_i != '0);
  assign rs2_valid_o = rs2_fwd.hit & (rs2_i != '0);

endmodule

// File: hdl/sb_pkg.sv
// Scoreboard shared types
package sb_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------
  // integer datapath width
  localparam int unsigned XLEN          = 32;
  localparam int unsigned REG_ADDR_SIZE = 5;
  localparam int unsigned NR_REGS       = 2 ** REG_ADDR_SIZE;

  // slot count, power of two so the pointers wrap on their own
  localparam int unsigned SB_ENTRIES    = 8;
  localparam int unsigned TRANS_ID_BITS = $clog2(SB_ENTRIES);

  // slot index handed back to the issue stage
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

  // ----------------------------------------------------------
  // entry types
  // ----------------------------------------------------------
  // unit that will produce the result
  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_LOAD,
    FU_STORE,
    FU_MULT,
    FU_CSR
  } fu_t;

  typedef struct packed {
    logic       valid;
    logic [5:0] cause;
  } exception_t;

  // one scoreboard slot
  typedef struct packed {
    logic [31:0]              pc;
    trans_id_t                trans_id;
    fu_t                      fu;
    logic [REG_ADDR_SIZE-1:0] rd;
    logic [XLEN-1:0]          result;
    logic                     valid;     // result is ready
    exception_t               ex;
  } sb_entry_t;

  // one write-back port from a unit
  typedef struct packed {
    logic            valid;
    trans_id_t       trans_id;
    logic [XLEN-1:0] data;
    exception_t      ex;
  } wb_port_t;

endpackage

// File: hdl/scoreboard.sv
// Instruction scoreboard top
`timescale 1ns/1ps

module scoreboard import sb_pkg::*; #(
  parameter int unsigned NR_WB_PORTS     = 1,
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  output logic                            sb_full_o,
  input  logic                            flush_unissued_instr_i,
  input  logic                            flush_i,
  input  logic                            unresolved_branch_i,
  // clobber map to issue
  output fu_t [NR_REGS-1:0]               rd_clobber_o,
  // operand reads
  input  logic [REG_ADDR_SIZE-1:0]        rs1_i,
  output logic [XLEN-1:0]                 rs1_o,
  output logic                            rs1_valid_o,
  input  logic [REG_ADDR_SIZE-1:0]        rs2_i,
  output logic [XLEN-1:0]                 rs2_o,
  output logic                            rs2_valid_o,
  // commit
  output sb_entry_t [NR_COMMIT_PORTS-1:0] commit_instr_o,
  input  logic [NR_COMMIT_PORTS-1:0]      commit_ack_i,
  // decode
  input  sb_entry_t                       decoded_instr_i,
  input  logic                            decoded_instr_valid_i,
  output logic                            decoded_instr_ack_o,
  // issue
  output sb_entry_t                       issue_instr_o,
  output logic                            issue_instr_valid_o,
  input  logic                            issue_ack_i,
  // write-back
  input  wb_port_t [NR_WB_PORTS-1:0]      wb_i
);

  logic [SB_ENTRIES-1:0]      slot_issued;
  sb_entry_t [SB_ENTRIES-1:0] slot_entry;

  // slots, pointers and handshakes
  sb_entry_store #(
    .NR_WB_PORTS     (NR_WB_PORTS),
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) i_sb_entry_store (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .flush_i                (flush_i),
    .flush_unissued_instr_i (flush_unissued_instr_i),
    .decoded_instr_i        (decoded_instr_i),
    .decoded_instr_valid_i  (decoded_instr_valid_i),
    .decoded_instr_ack_o    (decoded_instr_ack_o),
    .issue_instr_o          (issue_instr_o),
    .issue_instr_valid_o    (issue_instr_valid_o),
    .issue_ack_i            (issue_ack_i),
    .unresolved_branch_i    (unresolved_branch_i),
    .sb_full_o              (sb_full_o),
    .wb_i                   (wb_i),
    .commit_instr_o         (commit_instr_o),
    .commit_ack_i           (commit_ack_i),
    .slot_issued_o          (slot_issued),
    .slot_entry_o           (slot_entry)
  );

  // who writes which register
  sb_clobber i_sb_clobber (
    .slot_issued_i (slot_issued),
    .slot_entry_i  (slot_entry),
    .rd_clobber_o  (rd_clobber_o)
  );

  // result forwarding to operand read
  sb_operand_fwd #(
    .NR_WB_PORTS (NR_WB_PORTS)
  ) i_sb_operand_fwd (
    .slot_issued_i (slot_issued),
    .slot_entry_i  (slot_entry),
    .wb_i          (wb_i),
    .rs1_i         (rs1_i),
    .rs1_o         (rs1_o),
    .rs1_valid_o   (rs1_valid_o),
    .rs2_i         (rs2_i),
    .rs2_o         (rs2_o),
    .rs2_valid_o   (rs2_valid_o)
  );

endmodule

// File: run.sh
#!/bin/sh
# build and run the scoreboard testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
  --top-module tb_scoreboard -Mdir obj_dir || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_scoreboard 2>&1)
echo "$out"
echo "$out" | grep -q "NO ERRORS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: src.f
+incdir+dv
hdl/sb_pkg.sv
hdl/sb_entry_store.sv
hdl/sb_clobber.sv
hdl/sb_operand_fwd.sv
hdl/scoreboard.sv
dv/tb_scoreboard.sv
